//--- rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes, inst[6:0]
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // op-imm
    localparam funct3_t F3_ADDI  = 3'b000;
    localparam funct3_t F3_SLLI  = 3'b001;
    localparam funct3_t F3_SLTI  = 3'b010;
    localparam funct3_t F3_SLTIU = 3'b011;
    localparam funct3_t F3_XORI  = 3'b100;
    localparam funct3_t F3_SRLI  = 3'b101;
    localparam funct3_t F3_ORI   = 3'b110;
    localparam funct3_t F3_ANDI  = 3'b111;

    // op, funct7 zero only
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_JALR = 3'b000;

    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRS  = 3'b010;
    localparam funct3_t F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101;
    localparam funct3_t F3_CSRRSI = 3'b110;
    localparam funct3_t F3_CSRRCI = 3'b111;

    localparam funct7_t FUNCT7_BASE = 7'b0000000;

endpackage

//--- ex_pkg.sv
package ex_pkg;

    import rv_isa_pkg::*;

    // request as seen by the execute stage, csr_old already read upstream
    typedef struct packed {
        inst_t inst;
        xlen_t pc;
        xlen_t rs1;
        xlen_t rs2;
        xlen_t csr_old;
    } ex_req_t;

    typedef struct packed {
        logic      rd_we;
        reg_addr_t rd_addr;
        xlen_t     rd_data;
        logic      csr_we;
        csr_addr_t csr_addr;
        xlen_t     csr_wdata;
        logic      jump;
        xlen_t     jump_addr;
    } ex_rsp_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_PASS_B, ALU_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_op_e;

    typedef enum logic [2:0] {
        CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI
    } csr_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      op_b_sel;   // 1: immediate, 0: rs2
        br_op_e    br_op;
        csr_op_e   csr_op;
        logic      is_branch;
        logic      is_csr;
        logic      is_jump;    // jal or jalr
        logic      is_jalr;
        logic      is_auipc;
        logic      rd_we;
        reg_addr_t rd_addr;
        csr_addr_t csr_addr;
        xlen_t     imm;
        logic [4:0] csr_uimm;
    } ex_ctrl_t;

endpackage

//--- ex_pipe_slot.sv
`timescale 1ns/100ps

module ex_pipe_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;
    logic     load;

    // accept when empty or when being drained this cycle
    assign in_ready_o  = ~full_q | out_ready_i;
    assign load        = in_valid_i & in_ready_o;
    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            full_q <= 1'b0; // drained, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= in_data_i;
        end
    end

endmodule

//--- ex_decode.sv
`timescale 1ns/100ps

module ex_decode (
    input  rv_isa_pkg::inst_t  inst_i,
    input  rv_isa_pkg::xlen_t  rs2_data_i,
    output ex_pkg::ex_ctrl_t   ctrl_o,
    output rv_isa_pkg::xlen_t  op_b_o
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    xlen_t    imm_i, imm_b, imm_j, imm_u;
    ex_ctrl_t ctrl;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};

    always_comb begin
        ctrl          = '0;  // no write, no jump
        ctrl.alu_op   = ALU_NONE;
        ctrl.br_op    = BR_ALWAYS;
        ctrl.csr_op   = CSR_RW;
        ctrl.rd_addr  = inst_i[11:7];
        ctrl.csr_addr = inst_i[31:20];
        ctrl.csr_uimm = inst_i[19:15];
        ctrl.imm      = imm_i;
        case (opcode)
            OPC_OP_IMM: begin
                ctrl.op_b_sel = 1'b1;
                ctrl.rd_we    = 1'b1;
                case (funct3)
                    F3_ADDI:  ctrl.alu_op = ALU_ADD;
                    F3_SLTI:  ctrl.alu_op = ALU_SLT;
                    F3_SLTIU: ctrl.alu_op = ALU_SLTU;
                    F3_XORI:  ctrl.alu_op = ALU_XOR;
                    F3_ORI:   ctrl.alu_op = ALU_OR;
                    F3_ANDI:  ctrl.alu_op = ALU_AND;
                    F3_SLLI, F3_SRLI: begin
                        ctrl.alu_op = (funct3 == F3_SLLI) ? ALU_SLL : ALU_SRL;
                        ctrl.imm    = {27'd0, inst_i[24:20]}; // shamt
                        ctrl.rd_we  = (funct7 == FUNCT7_BASE); // srai not supported
                    end
                    default: ctrl.rd_we = 1'b0;
                endcase
            end
            OPC_OP: begin
                ctrl.rd_we = (funct7 == FUNCT7_BASE);
                case (funct3)
                    F3_ADD:  ctrl.alu_op = ALU_ADD;
                    F3_SLL:  ctrl.alu_op = ALU_SLL;
                    F3_SLT:  ctrl.alu_op = ALU_SLT;
                    F3_SLTU: ctrl.alu_op = ALU_SLTU;
                    F3_XOR:  ctrl.alu_op = ALU_XOR;
                    F3_SRL:  ctrl.alu_op = ALU_SRL;
                    F3_OR:   ctrl.alu_op = ALU_OR;
                    F3_AND:  ctrl.alu_op = ALU_AND;
                    default: ctrl.rd_we  = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                ctrl.imm       = imm_b;
                ctrl.is_branch = 1'b1;
                case (funct3)
                    F3_BEQ:  ctrl.br_op = BR_EQ;
                    F3_BNE:  ctrl.br_op = BR_NE;
                    F3_BLT:  ctrl.br_op = BR_LT;
                    F3_BGE:  ctrl.br_op = BR_GE;
                    F3_BLTU: ctrl.br_op = BR_LTU;
                    F3_BGEU: ctrl.br_op = BR_GEU;
                    default: ctrl.is_branch = 1'b0;
                endcase
            end
            OPC_JAL: begin
                ctrl.imm     = imm_j;
                ctrl.is_jump = 1'b1;
                ctrl.rd_we   = 1'b1;
            end
            OPC_JALR: begin
                ctrl.is_jump = (funct3 == F3_JALR);
                ctrl.is_jalr = (funct3 == F3_JALR);
                ctrl.rd_we   = (funct3 == F3_JALR);
            end
            OPC_LUI: begin
                ctrl.imm      = imm_u;
                ctrl.op_b_sel = 1'b1;
                ctrl.alu_op   = ALU_PASS_B;
                ctrl.rd_we    = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm      = imm_u;
                ctrl.is_auipc = 1'b1;
                ctrl.rd_we    = 1'b1;
            end
            OPC_SYSTEM: begin
                ctrl.is_csr = 1'b1;
                ctrl.rd_we  = 1'b1;
                case (funct3)
                    F3_CSRRW:  ctrl.csr_op = CSR_RW;
                    F3_CSRRS:  ctrl.csr_op = CSR_RS;
                    F3_CSRRC:  ctrl.csr_op = CSR_RC;
                    F3_CSRRWI: ctrl.csr_op = CSR_RWI;
                    F3_CSRRSI: ctrl.csr_op = CSR_RSI;
                    F3_CSRRCI: ctrl.csr_op = CSR_RCI;
                    default: begin
                        ctrl.is_csr = 1'b0; // ecall, ebreak and friends
                        ctrl.rd_we  = 1'b0;
                    end
                endcase
            end
            default: ;
        endcase
    end

    assign ctrl_o = ctrl;
    assign op_b_o = ctrl.op_b_sel ? ctrl.imm : rs2_data_i;

endmodule

//--- ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
    input  ex_pkg::alu_op_e   op_i,
    input  rv_isa_pkg::xlen_t a_i,
    input  rv_isa_pkg::xlen_t b_i,
    output rv_isa_pkg::xlen_t result_o
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SLT:    result_o = {31'd0, lt_s};
            ALU_SLTU:   result_o = {31'd0, lt_u};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SRL:    result_o = a_i >> shamt;  // logical
            ALU_PASS_B: result_o = b_i;           // lui
            ALU_NONE:   result_o = '0;
            default:    result_o = '0;
        endcase
    end

endmodule

//--- ex_branch.sv
`timescale 1ns/100ps

module ex_branch (
    input  ex_pkg::br_op_e    op_i,
    input  logic              is_jalr_i,
    input  rv_isa_pkg::xlen_t pc_i,
    input  rv_isa_pkg::xlen_t rs1_i,
    input  rv_isa_pkg::xlen_t rs2_i,
    input  rv_isa_pkg::xlen_t imm_i,
    output logic              jump_o,
    output rv_isa_pkg::xlen_t jump_addr_o
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    xlen_t base;
    xlen_t sum;

    always_comb begin
        case (op_i)
            BR_EQ:     jump_o = (rs1_i == rs2_i);
            BR_NE:     jump_o = (rs1_i != rs2_i);
            BR_LT:     jump_o = $signed(rs1_i) < $signed(rs2_i);
            BR_GE:     jump_o = $signed(rs1_i) >= $signed(rs2_i);
            BR_LTU:    jump_o = rs1_i < rs2_i;
            BR_GEU:    jump_o = rs1_i >= rs2_i;
            BR_ALWAYS: jump_o = 1'b1;
            default:   jump_o = 1'b0;
        endcase
    end

    assign base        = is_jalr_i ? rs1_i : pc_i;
    assign sum         = base + imm_i;
    assign jump_addr_o = {sum[31:1], sum[0] & ~is_jalr_i}; // jalr clears bit 0

endmodule

//--- ex_csr.sv
`timescale 1ns/100ps

module ex_csr (
    input  ex_pkg::csr_op_e   op_i,
    input  rv_isa_pkg::xlen_t old_i,
    input  rv_isa_pkg::xlen_t rs1_i,
    input  logic [4:0]        uimm_i,
    output rv_isa_pkg::xlen_t wdata_o
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    xlen_t src;

    // immediate forms take the zero-extended rs1 field
    assign src = (op_i inside {CSR_RWI, CSR_RSI, CSR_RCI}) ? {27'd0, uimm_i} : rs1_i;

    always_comb begin
        case (op_i)
            CSR_RW, CSR_RWI: wdata_o = src;
            CSR_RS, CSR_RSI: wdata_o = old_i | src;
            CSR_RC, CSR_RCI: wdata_o = old_i & ~src;
            default:         wdata_o = old_i;
        endcase
    end

endmodule

//--- ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_rsp_t rsp_o
);

    import rv_isa_pkg::*;
    import ex_pkg::*;

    ex_ctrl_t ctrl;
    xlen_t    op_b;
    xlen_t    alu_res;
    xlen_t    br_target;
    xlen_t    csr_wdata;
    xlen_t    rd_data;
    logic     br_taken;
    logic     rd_we;
    logic     is_xfer;

    ex_decode u_decode (
        .inst_i     (req_i.inst),
        .rs2_data_i (req_i.rs2),
        .ctrl_o     (ctrl),
        .op_b_o     (op_b)
    );

    ex_alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (req_i.rs1),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    ex_branch u_branch (
        .op_i        (ctrl.br_op),
        .is_jalr_i   (ctrl.is_jalr),
        .pc_i        (req_i.pc),
        .rs1_i       (req_i.rs1),
        .rs2_i       (req_i.rs2),
        .imm_i       (ctrl.imm),
        .jump_o      (br_taken),
        .jump_addr_o (br_target)
    );

    ex_csr u_csr (
        .op_i    (ctrl.csr_op),
        .old_i   (req_i.csr_old),
        .rs1_i   (req_i.rs1),
        .uimm_i  (ctrl.csr_uimm),
        .wdata_o (csr_wdata)
    );

    always_comb begin
        if (ctrl.is_jump) begin
            rd_data = req_i.pc + 32'd4;  // link address
        end else if (ctrl.is_csr) begin
            rd_data = req_i.csr_old;
        end else if (ctrl.is_auipc) begin
            rd_data = br_target;         // pc + imm from the target adder
        end else begin
            rd_data = alu_res;
        end
    end

    assign rd_we   = ctrl.rd_we & (ctrl.rd_addr != '0);
    assign is_xfer = ctrl.is_branch | ctrl.is_jump;

    // payload fields read as zero when their enable is low
    always_comb begin
        rsp_o.rd_we     = rd_we;
        rsp_o.rd_addr   = rd_we ? ctrl.rd_addr : '0;
        rsp_o.rd_data   = rd_we ? rd_data : '0;
        rsp_o.csr_we    = ctrl.is_csr;
        rsp_o.csr_addr  = ctrl.is_csr ? ctrl.csr_addr : '0;
        rsp_o.csr_wdata = ctrl.is_csr ? csr_wdata : '0;
        rsp_o.jump      = is_xfer & br_taken;
        rsp_o.jump_addr = is_xfer ? br_target : '0;
    end

endmodule

//--- ex_top.sv
`timescale 1ns/100ps

module ex_top (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  ex_pkg::ex_req_t req_i,
    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output ex_pkg::ex_rsp_t rsp_o
);

    import ex_pkg::*;

    ex_req_t req_q;
    ex_rsp_t rsp_d;
    logic    req_q_valid;
    logic    rsp_slot_ready;

    ex_pipe_slot #(.payload_t(ex_req_t)) u_req_slot (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .in_data_i   (req_i),
        .out_valid_o (req_q_valid),
        .out_ready_i (rsp_slot_ready),
        .out_data_o  (req_q)
    );

    ex_stage u_stage (
        .req_i (req_q),
        .rsp_o (rsp_d)
    );

    ex_pipe_slot #(.payload_t(ex_rsp_t)) u_rsp_slot (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (req_q_valid),
        .in_ready_o  (rsp_slot_ready),
        .in_data_i   (rsp_d),
        .out_valid_o (rsp_valid_o),
        .out_ready_i (rsp_ready_i),
        .out_data_o  (rsp_o)
    );

endmodule

//--- tb_ex_top.sv
`timescale 1ns/100ps

module tb_ex_top;

    import ex_pkg::*;

    localparam int NUM_VEC    = 27;
    localparam int VEC_WORDS  = 13;  // 5 request words, 8 expected words
    localparam int RST_CYCLES = 8;
    localparam int CLK_PERIOD = 10;

    logic    clk_i;
    logic    rst_n_i;
    logic    req_valid_i;
    logic    req_ready_o;
    ex_req_t req_i;
    logic    rsp_valid_o;
    logic    rsp_ready_i;
    ex_rsp_t rsp_o;

    logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];
    int          seed;
    int          sent_cnt;
    int          recv_cnt;

    ex_top UUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic end_in_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s actual=%h expected=%h", $time, name, actual, expected);
            end_in_failure();
        end
    endtask

    function automatic ex_req_t request_of(input int idx);
        ex_req_t req;
        int      base;
        base        = idx * VEC_WORDS;
        req.inst    = vec_mem[base];
        req.pc      = vec_mem[base+1];
        req.rs1     = vec_mem[base+2];
        req.rs2     = vec_mem[base+3];
        req.csr_old = vec_mem[base+4];
        return req;
    endfunction

    task automatic compare_response(input int idx);
        int base;
        base = idx * VEC_WORDS + 5;  // expected fields follow the request
        check_value("rd_we",     rsp_o.rd_we,     vec_mem[base]);
        check_value("rd_addr",   rsp_o.rd_addr,   vec_mem[base+1]);
        check_value("rd_data",   rsp_o.rd_data,   vec_mem[base+2]);
        check_value("csr_we",    rsp_o.csr_we,    vec_mem[base+3]);
        check_value("csr_addr",  rsp_o.csr_addr,  vec_mem[base+4]);
        check_value("csr_wdata", rsp_o.csr_wdata, vec_mem[base+5]);
        check_value("jump",      rsp_o.jump,      vec_mem[base+6]);
        check_value("jump_addr", rsp_o.jump_addr, vec_mem[base+7]);
    endtask

    // valid held with stable payload until the edge where ready is seen
    task automatic drive_requests();
        int idx;
        int gap;
        @(posedge clk_i);
        for (idx = 0; idx < NUM_VEC; idx++) begin
            gap = $unsigned($random(seed)) % 4;
            req_valid_i <= 1'b0;
            repeat (gap) @(posedge clk_i);
            req_valid_i <= 1'b1;
            req_i       <= request_of(idx);
            @(posedge clk_i);
            while (!req_ready_o) @(posedge clk_i);
            sent_cnt++;
        end
        req_valid_i <= 1'b0;
    endtask

    task automatic collect_responses();
        while (recv_cnt < NUM_VEC) begin
            @(posedge clk_i);
            if (rsp_valid_o && recv_cnt >= sent_cnt) begin
                $display("a response showed up at %0t with no request outstanding", $time);
                end_in_failure();
            end
            if (rsp_valid_o && rsp_ready_i) begin
                compare_response(recv_cnt);
                recv_cnt++;
            end
            rsp_ready_i <= (($random(seed) & 3) != 0);  // ready about 3 of 4 cycles
        end
        rsp_ready_i <= 1'b1;
    endtask

    initial begin
        #((NUM_VEC * 20 + RST_CYCLES) * CLK_PERIOD);
        $display("timeout: responses stopped arriving, %0d of %0d received",
                 recv_cnt, NUM_VEC);
        end_in_failure();
    end

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        seed        = 32'h257f;
        sent_cnt    = 0;
        recv_cnt    = 0;

        $readmemh("ex_testdata.txt", vec_mem);
        if (^vec_mem[NUM_VEC*VEC_WORDS-1] === 1'bx) begin
            $display("test data file is missing or holds fewer vectors than expected");
            end_in_failure();
        end

        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        fork
            drive_requests();
            collect_responses();
        join

        // nothing may follow the last response
        repeat (5) begin
            @(posedge clk_i);
            if (rsp_valid_o) begin
                $display("an extra response appeared after the last expected one");
                end_in_failure();
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- ex_testdata.txt
// inst pc rs1 rs2 csr_old, then expected rd_we rd_addr rd_data csr_we csr_addr csr_wdata
// jump jump_addr; all hex, one vector per line
FFF08293 00000100 00000010 00000000 00000000 1 05 0000000F 0 000 00000000 0 00000000
0010A313 00000104 FFFFFFFF 00000000 00000000 1 06 00000001 0 000 00000000 0 00000000
0F00C413 00000108 000000FF 00000000 00000000 1 08 0000000F 0 000 00000000 0 00000000
00409593 0000010C 80000001 00000000 00000000 1 0B 00000010 0 000 00000000 0 00000000
0020A7B3 00000110 80000000 00000001 00000000 1 0F 00000001 0 000 00000000 0 00000000
0020B833 00000114 80000000 00000001 00000000 1 10 00000000 0 000 00000000 0 00000000
0020C8B3 00000118 F0F0F0F0 FF00FF00 00000000 1 11 0FF00FF0 0 000 00000000 0 00000000
0020D933 0000011C F0000000 00000024 00000000 1 12 0F000000 0 000 00000000 0 00000000
0020E033 00000120 00000001 00000002 00000000 0 00 00000000 0 000 00000000 0 00000000
00208863 00000124 00000005 00000005 00000000 0 00 00000000 0 000 00000000 1 00000134
FE209CE3 00000128 00000005 00000005 00000000 0 00 00000000 0 000 00000000 0 00000120
0020C863 0000012C FFFFFFFF 00000001 00000000 0 00 00000000 0 000 00000000 1 0000013C
0020D863 00000130 FFFFFFFF 00000001 00000000 0 00 00000000 0 000 00000000 0 00000140
0020E863 00000134 FFFFFFFF 00000001 00000000 0 00 00000000 0 000 00000000 0 00000144
0020F863 00000138 FFFFFFFF 00000001 00000000 0 00 00000000 0 000 00000000 1 00000148
100000EF 0000013C 00000000 00000000 00000000 1 01 00000140 0 000 00000000 1 0000023C
005080E7 00000140 00001000 00000000 00000000 1 01 00000144 0 000 00000000 1 00001004
123451B7 00000144 00000000 00000000 00000000 1 03 12345000 0 000 00000000 0 00000000
FFFFF217 00000148 00000000 00000000 00000000 1 04 FFFFF148 0 000 00000000 0 00000000
300092F3 0000014C AAAA5555 00000000 00001888 1 05 00001888 1 300 AAAA5555 0 00000000
3000A2F3 00000150 0000000F 00000000 000000F0 1 05 000000F0 1 300 000000FF 0 00000000
3000B2F3 00000154 0000000F 00000000 000000FF 1 05 000000FF 1 300 000000F0 0 00000000
305FD2F3 00000158 DEADBEEF 00000000 12345678 1 05 12345678 1 305 0000001F 0 00000000
3411E073 0000015C DEADBEEF 00000000 00000100 0 00 00000000 1 341 00000103 0 00000000
3002F373 00000160 FFFFFFFF 00000000 0000000F 1 06 0000000F 1 300 0000000A 0 00000000
0050828B 00000164 00000001 00000002 00000000 0 00 00000000 0 000 00000000 0 00000000
402086B3 00000168 00000005 00000003 00000000 0 00 00000000 0 000 00000000 0 00000000

//--- verilog.f
rv_isa_pkg.sv
ex_pkg.sv
ex_pipe_slot.sv
ex_decode.sv
ex_alu.sv
ex_branch.sv
ex_csr.sv
ex_stage.sv
ex_top.sv
tb_ex_top.sv

//--- Bender.yml
package:
  name: rv32i_ex_stage

sources:
  - rv_isa_pkg.sv
  - ex_pkg.sv
  - ex_pipe_slot.sv
  - ex_decode.sv
  - ex_alu.sv
  - ex_branch.sv
  - ex_csr.sv
  - ex_stage.sv
  - ex_top.sv
  - target: simulation
    files:
      - tb_ex_top.sv
